// ==== rtl/cbus_axi_defs.svh ====
`ifndef CBUS_AXI_DEFS_SVH
`define CBUS_AXI_DEFS_SVH

// byte address width
`define ADDR_W 32

// word width, four bytes per beat
`define DATA_W 32

// order field of a cache request, orders 0 to 7
`define ORDER_W 3

// AXI burst length field, at most 16 beats
`define AXI_LEN_W 4

// entries in the command buffer
`define CMD_DEPTH 2

// size of the on-chip memory in words
`define MEM_WORDS 1024

`endif

// ==== rtl/cbus_axi_pkg.sv ====
`include "cbus_axi_defs.svh"

package cbus_axi_pkg;

    typedef logic [`ADDR_W-1:0]    addr_t;
    typedef logic [`DATA_W-1:0]    data_t;
    typedef logic [`ORDER_W-1:0]   order_t;
    typedef logic [`AXI_LEN_W-1:0] axi_len_t;

    // bits of (words per request - 1) for the largest order
    localparam int WORDS_W = (1 << `ORDER_W) - 1;

    // round count covers what the largest request needs beyond one burst
    localparam int ROUND_W = (WORDS_W > `AXI_LEN_W) ? WORDS_W - `AXI_LEN_W : 1;

    // rounds and burst length packed together
    localparam int SPLIT_W = ROUND_W + `AXI_LEN_W;

    typedef logic [ROUND_W-1:0] round_t;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        TRANSFER
    } bridge_state_t;

endpackage

// ==== rtl/axi_if.sv ====
// burst command channel, shared by AW and AR
interface axi_cmd_if;
    import cbus_axi_pkg::*;

    logic     valid;
    logic     ready;
    addr_t    addr;
    axi_len_t len;
    logic     write;

    modport master (
        output valid, addr, len, write,
        input  ready
    );

    modport slave (
        input  valid, addr, len, write,
        output ready
    );
endinterface

// write and read data channels
interface axi_data_if;
    import cbus_axi_pkg::*;

    logic  wvalid;
    data_t wdata;
    logic  wlast;
    logic  wready;

    logic  rvalid;
    data_t rdata;
    logic  rlast;
    logic  rready;

    // the bridge drives W and sinks R
    modport master (
        output wvalid, wdata, wlast, rready,
        input  wready, rvalid, rdata, rlast
    );

    modport slave (
        input  wvalid, wdata, wlast, rready,
        output wready, rvalid, rdata, rlast
    );
endinterface

// ==== rtl/cbus_to_axi.sv ====
`include "cbus_axi_defs.svh"

module cbus_to_axi (
    input  logic                 clk,
    input  logic                 resetn,

    input  logic                 cbus_valid,
    input  logic                 cbus_write,
    input  cbus_axi_pkg::addr_t  cbus_addr,
    input  cbus_axi_pkg::order_t cbus_order,
    input  cbus_axi_pkg::data_t  cbus_wdata,
    output logic                 cbus_okay,
    output logic                 cbus_last,
    output cbus_axi_pkg::data_t  cbus_rdata,

    axi_cmd_if.master            cmd,
    axi_data_if.master           data
);
    import cbus_axi_pkg::*;

    localparam int BYTE_SHIFT = $clog2(`DATA_W / 8);

    // words minus one, split into rounds and burst length
    // the length saturates at 16 beats once the order reaches 4
    logic [SPLIT_W-1:0] words_m1;
    axi_len_t           axi_len;
    round_t             num_round;

    assign words_m1 = (SPLIT_W'(1) << cbus_order) - SPLIT_W'(1);
    assign {num_round, axi_len} = words_m1;

    // bytes covered by one burst
    addr_t addr_step;
    assign addr_step = (addr_t'(axi_len) + addr_t'(1)) << BYTE_SHIFT;

    bridge_state_t state;
    addr_t         current_addr;
    round_t        round_cnt;
    axi_len_t      len_cnt;

    logic is_last;
    logic is_final;
    logic cmd_fire;
    logic beat_fire;

    assign is_last  = len_cnt == '0;
    assign is_final = is_last && round_cnt == '0;
    assign cmd_fire = cmd.valid && cmd.ready;

    // only one of the two channels is active for a request
    assign beat_fire = cbus_write ? (data.wvalid && data.wready)
                                  : (data.rvalid && data.rready);

    // command channel: first burst straight from the request, later ones
    // from the stepped address
    assign cmd.valid = (state == IDLE && cbus_valid) || state == REQUEST;
    assign cmd.addr  = (state == REQUEST) ? current_addr : cbus_addr;
    assign cmd.len   = axi_len;
    assign cmd.write = cbus_write;

    assign data.wvalid = state == TRANSFER && cbus_write;
    assign data.wdata  = cbus_wdata;
    assign data.wlast  = is_last;
    assign data.rready = state == TRANSFER && !cbus_write;

    // cache side response follows the beat handshakes
    assign cbus_okay  = state == TRANSFER && beat_fire;
    assign cbus_last  = cbus_okay && is_final;
    assign cbus_rdata = data.rdata;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state     <= IDLE;
            round_cnt <= '0;
            len_cnt   <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (cmd_fire) begin
                        state     <= TRANSFER;
                        round_cnt <= num_round;
                        len_cnt   <= axi_len;
                    end
                end

                REQUEST: begin
                    if (cmd_fire) begin
                        state     <= TRANSFER;
                        round_cnt <= round_cnt - round_t'(1);
                        len_cnt   <= axi_len;
                    end
                end

                TRANSFER: begin
                    if (beat_fire) begin
                        if (is_final) begin
                            state <= IDLE;
                        end else if (is_last) begin
                            // burst done, post the next round
                            state <= REQUEST;
                        end else begin
                            len_cnt <= len_cnt - axi_len_t'(1);
                        end
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // address of the burst to come
    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_fire) begin
            current_addr <= cbus_addr;
        end else if (state == TRANSFER && beat_fire && is_last && !is_final) begin
            current_addr <= current_addr + addr_step;
        end
    end

endmodule

// ==== rtl/axi_cmd_fifo.sv ====
`include "cbus_axi_defs.svh"

module axi_cmd_fifo (
    input  logic      clk,
    input  logic      resetn,
    axi_cmd_if.slave  in,
    axi_cmd_if.master out
);
    import cbus_axi_pkg::*;

    localparam int PTR_W = (`CMD_DEPTH > 1) ? $clog2(`CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(`CMD_DEPTH + 1);

    addr_t    addr_mem  [`CMD_DEPTH];
    axi_len_t len_mem   [`CMD_DEPTH];
    logic     write_mem [`CMD_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(`CMD_DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign in.ready  = count != CNT_W'(`CMD_DEPTH);
    assign out.valid = count != '0;

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    // head entry stays put until the memory takes it
    assign out.addr  = addr_mem[rd_ptr];
    assign out.len   = len_mem[rd_ptr];
    assign out.write = write_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr]  <= in.addr;
            len_mem[wr_ptr]   <= in.len;
            write_mem[wr_ptr] <= in.write;
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // push and pop together leave the count alone
            if (push && !pop) begin
                count <= count + CNT_W'(1);
            end else if (pop && !push) begin
                count <= count - CNT_W'(1);
            end
        end
    end

endmodule

// ==== rtl/axi_mem_slave.sv ====
`include "cbus_axi_defs.svh"

module axi_mem_slave (
    input  logic      clk,
    input  logic      resetn,
    axi_cmd_if.slave  cmd,
    axi_data_if.slave data
);
    import cbus_axi_pkg::*;

    localparam int IDX_W      = $clog2(`MEM_WORDS);
    localparam int BYTE_SHIFT = $clog2(`DATA_W / 8);

    localparam addr_t WORD_BYTES = addr_t'(`DATA_W / 8);

    data_t mem [`MEM_WORDS];

    // command register
    logic     busy;
    logic     write_q;
    axi_len_t len_q;
    addr_t    addr_q;

    // index of the read beat on the bus
    axi_len_t beat_cnt;

    logic cmd_fire;
    logic r_fire;
    logic w_fire;
    logic rd_load;

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    function automatic logic [IDX_W-1:0] word_idx(input addr_t a);
        return a[BYTE_SHIFT +: IDX_W];
    endfunction

    assign cmd.ready   = !busy;
    assign data.wready = busy && write_q;

    assign cmd_fire = cmd.valid && cmd.ready;
    assign r_fire   = data.rvalid && data.rready;
    assign w_fire   = data.wvalid && data.wready;

    // fetch the first word with the command, later words as beats drain
    assign rd_load = (cmd_fire && !cmd.write) || (r_fire && !data.rlast);
    assign rd_idx  = cmd_fire ? word_idx(cmd.addr) : word_idx(addr_q);
    assign wr_idx  = word_idx(addr_q);

    always_ff @(posedge clk) begin
        if (resetn) begin
            busy        <= 1'b0;
            write_q     <= 1'b0;
            len_q       <= '0;
            beat_cnt    <= '0;
            data.rvalid <= 1'b0;
            data.rlast  <= 1'b0;
        end else if (cmd_fire) begin
            busy        <= 1'b1;
            write_q     <= cmd.write;
            len_q       <= cmd.len;
            beat_cnt    <= '0;
            data.rvalid <= !cmd.write;
            data.rlast  <= !cmd.write && cmd.len == '0;
        end else if (r_fire) begin
            if (data.rlast) begin
                busy        <= 1'b0;
                data.rvalid <= 1'b0;
                data.rlast  <= 1'b0;
            end else begin
                beat_cnt   <= beat_cnt + axi_len_t'(1);
                data.rlast <= axi_len_t'(beat_cnt + axi_len_t'(1)) == len_q;
            end
        end else if (w_fire && data.wlast) begin
            busy <= 1'b0;
        end
    end

    // INCR address walk
    // a read runs one word ahead since the first word is fetched with the command
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            addr_q <= cmd.write ? cmd.addr : cmd.addr + WORD_BYTES;
        end else if (r_fire || w_fire) begin
            addr_q <= addr_q + WORD_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (w_fire) begin
            mem[wr_idx] <= data.wdata;
        end
        if (rd_load) begin
            data.rdata <= mem[rd_idx];
        end
    end

endmodule

// ==== rtl/cbus_axi_top.sv ====
module cbus_axi_top (
    input  logic                 clk,
    input  logic                 resetn,

    input  logic                 cbus_valid,
    input  logic                 cbus_write,
    input  cbus_axi_pkg::addr_t  cbus_addr,
    input  cbus_axi_pkg::order_t cbus_order,
    input  cbus_axi_pkg::data_t  cbus_wdata,
    output logic                 cbus_okay,
    output cbus_axi_pkg::data_t  cbus_rdata,
    output logic                 cbus_last
);

    // bridge to buffer, buffer to memory
    axi_cmd_if  cmd_in ();
    axi_cmd_if  cmd_out ();
    axi_data_if data ();

    cbus_to_axi u_bridge (
        .clk        (clk),
        .resetn     (resetn),
        .cbus_valid (cbus_valid),
        .cbus_write (cbus_write),
        .cbus_addr  (cbus_addr),
        .cbus_order (cbus_order),
        .cbus_wdata (cbus_wdata),
        .cbus_okay  (cbus_okay),
        .cbus_last  (cbus_last),
        .cbus_rdata (cbus_rdata),
        .cmd        (cmd_in.master),
        .data       (data.master)
    );

    axi_cmd_fifo u_cmd_fifo (
        .clk    (clk),
        .resetn (resetn),
        .in     (cmd_in.slave),
        .out    (cmd_out.master)
    );

    // data beats go straight between bridge and memory
    axi_mem_slave u_mem (
        .clk    (clk),
        .resetn (resetn),
        .cmd    (cmd_out.slave),
        .data   (data.slave)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// ==== tb/cbus_axi_assert.sv ====
module cbus_axi_assert (
    input logic                     clk,
    input logic                     resetn,
    input logic                     cbus_valid,
    input logic                     cbus_okay,
    input logic                     cbus_last,
    input logic                     cmd_valid,
    input logic                     cmd_ready,
    input cbus_axi_pkg::addr_t      cmd_addr,
    input cbus_axi_pkg::axi_len_t   cmd_len,
    input logic                     cmd_write
);

    // failures seen so far, read by the testbench at the end
    int fail_count = 0;

    // last marks the final okay of a request and no okay follows it
    a_last_with_okay: assert property (
        @(posedge clk) disable iff (resetn) cbus_last |-> cbus_okay ##1 !cbus_okay
    ) else begin
        fail_count++;
        $error("cbus_last without cbus_okay or the request did not end");
    end

    // a stalled command keeps its payload
    a_cmd_stable: assert property (
        @(posedge clk) disable iff (resetn)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_addr)
                                    && $stable(cmd_len) && $stable(cmd_write)
    ) else begin
        fail_count++;
        $error("command changed while waiting for ready");
    end

    a_okay_needs_valid: assert property (
        @(posedge clk) disable iff (resetn) cbus_okay |-> cbus_valid
    ) else begin
        fail_count++;
        $error("cbus_okay without a request");
    end

endmodule

bind cbus_axi_top cbus_axi_assert u_assert (
    .clk        (clk),
    .resetn     (resetn),
    .cbus_valid (cbus_valid),
    .cbus_okay  (cbus_okay),
    .cbus_last  (cbus_last),
    .cmd_valid  (cmd_in.valid),
    .cmd_ready  (cmd_in.ready),
    .cmd_addr   (cmd_in.addr),
    .cmd_len    (cmd_in.len),
    .cmd_write  (cmd_in.write)
);

// ==== tb/tb_cbus_axi.sv ====
`include "cbus_axi_defs.svh"

module tb_cbus_axi;
    import cbus_axi_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int DRIVE_DELAY  = 10;
    localparam int NUM_RANDOM   = 200;

    logic   clk;
    logic   resetn;
    logic   cbus_valid;
    logic   cbus_write;
    addr_t  cbus_addr;
    order_t cbus_order;
    data_t  cbus_wdata;
    logic   cbus_okay;
    data_t  cbus_rdata;
    logic   cbus_last;

    // word model of the memory behind the bridge
    data_t ref_mem [`MEM_WORDS];

    // request list, built up front so the watchdog knows the run length
    logic   req_write [$];
    addr_t  req_addr  [$];
    order_t req_order [$];
    logic   req_fill  [$];

    // request currently on the bus, shared with the compare process
    logic  cur_write;
    addr_t cur_addr;
    int    cur_words;
    data_t cur_data [$];
    int    beat_idx;

    int error_count;
    int check_count;
    int budget_cycles;

    tb_clock_gen #(.PERIOD(100)) u_clk (.clk(clk));

    cbus_axi_top DUT (
        .clk        (clk),
        .resetn     (resetn),
        .cbus_valid (cbus_valid),
        .cbus_write (cbus_write),
        .cbus_addr  (cbus_addr),
        .cbus_order (cbus_order),
        .cbus_wdata (cbus_wdata),
        .cbus_okay  (cbus_okay),
        .cbus_rdata (cbus_rdata),
        .cbus_last  (cbus_last)
    );

    function automatic int word_index(input addr_t a);
        return int'(a >> 2) % `MEM_WORDS;
    endfunction

    // expected read data for any byte address
    function automatic data_t ref_read(input addr_t a);
        return ref_mem[word_index(a)];
    endfunction

    function automatic data_t fill_word(input addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    task automatic compare_value(input string name, input data_t got, input data_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_request(input logic write, input addr_t addr, input order_t order,
                               input logic fill);
        req_write.push_back(write);
        req_addr.push_back(addr);
        req_order.push_back(order);
        req_fill.push_back(fill);
        budget_cycles += ((1 << order) + 8) * 2;
    endtask

    // holds the request until the okay with last, one word per okay on writes
    task automatic run_request(input logic write, input addr_t addr, input order_t order,
                               input logic fill);
        int   words;
        logic done;
        words = 1 << order;
        cur_data.delete();
        for (int k = 0; k < words; k++) begin
            cur_data.push_back(fill ? fill_word(addr + addr_t'(4 * k)) : data_t'($urandom));
        end
        cur_write  = write;
        cur_addr   = addr;
        cur_words  = words;
        beat_idx   = 0;
        cbus_valid = 1'b1;
        cbus_write = write;
        cbus_addr  = addr;
        cbus_order = order;
        cbus_wdata = cur_data[0];
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = cbus_okay && cbus_last;
            @(posedge clk);
            #DRIVE_DELAY;
            if (beat_idx < words) begin
                cbus_wdata = cur_data[beat_idx];
            end
        end
        cbus_valid = 1'b0;
        compare_value("okay count", data_t'(beat_idx), data_t'(words));
    endtask

    // compare process, sampled mid-cycle where the handshake is settled
    // reset is active high
    always @(negedge clk) begin
        if (!resetn && cbus_okay) begin
            compare_value("cbus_last", data_t'(cbus_last),
                          data_t'(beat_idx == cur_words - 1));
            if (beat_idx < cur_words) begin
                if (cur_write) begin
                    ref_mem[word_index(cur_addr + addr_t'(4 * beat_idx))] = cur_data[beat_idx];
                end else begin
                    compare_value("cbus_rdata", cbus_rdata,
                                  ref_read(cur_addr + addr_t'(4 * beat_idx)));
                end
            end
            beat_idx++;
        end
    end

    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clk);
        $display("timeout: requests did not complete within %0d cycles", budget_cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        int   words;
        int   assert_fails;
        order_t order;
        resetn      = 1'b1;
        cbus_valid  = 1'b0;
        cbus_write  = 1'b0;
        cbus_addr   = '0;
        cbus_order  = '0;
        cbus_wdata  = '0;
        error_count = 0;
        check_count = 0;
        beat_idx    = 0;
        cur_words   = 0;
        cur_write   = 1'b0;
        cur_addr    = '0;
        void'($urandom(32'h2f0d8f55));

        // preload the whole memory, each write is eight 16-beat bursts
        budget_cycles = RESET_CYCLES + 200;
        for (int k = 0; k < 8; k++) begin
            add_request(1'b1, addr_t'(k * 512), order_t'(7), 1'b1);
        end
        add_request(1'b1, 32'h0000_0104, order_t'(0), 1'b0);
        add_request(1'b0, 32'h0000_0104, order_t'(0), 1'b0);
        add_request(1'b1, 32'h0000_0240, order_t'(4), 1'b0);
        add_request(1'b0, 32'h0000_0240, order_t'(4), 1'b0);
        // four bursts per request
        add_request(1'b1, 32'h0000_0500, order_t'(6), 1'b0);
        add_request(1'b0, 32'h0000_0500, order_t'(6), 1'b0);
        for (int k = 0; k < NUM_RANDOM; k++) begin
            order = order_t'($urandom_range(7, 0));
            words = 1 << order;
            add_request(logic'($urandom_range(1, 0)),
                        addr_t'(int'($urandom_range(`MEM_WORDS / words - 1, 0)) * words * 4),
                        order, 1'b0);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        resetn = 1'b0;

        // idle bus after reset
        repeat (4) begin
            @(negedge clk);
            compare_value("cbus_okay", data_t'(cbus_okay), '0);
            compare_value("cbus_last", data_t'(cbus_last), '0);
        end
        @(posedge clk);
        #DRIVE_DELAY;

        for (int i = 0; i < req_addr.size(); i++) begin
            run_request(req_write[i], req_addr[i], req_order[i], req_fill[i]);
        end

        repeat (2) @(posedge clk);
        assert_fails = DUT.u_assert.fail_count;
        $display("requests %0d, checks %0d, errors %0d, assertion failures %0d",
                 req_addr.size(), check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/cbus_axi_pkg.sv
rtl/axi_if.sv
rtl/cbus_to_axi.sv
rtl/axi_cmd_fifo.sv
rtl/axi_mem_slave.sv
rtl/cbus_axi_top.sv
tb/tb_clock_gen.sv
tb/cbus_axi_assert.sv
tb/tb_cbus_axi.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing --assert -Wno-fatal
TOP       := tb_cbus_axi
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message shows up on a line of its own
sim:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
